// ==== src/rv_decode_pkg.sv ====
package rv_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_XREGS  = 32;  // Also width of reg_req
  localparam int CREDITS    = 4;   // Issue queue depth
  localparam int CREDIT_W   = $clog2(CREDITS + 1);
  localparam int CNT_W      = 16;

  // Major opcodes
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_MISC_MEM  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB, SRA and friends
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // System instructions match on the whole word
  localparam logic [31:0] ENC_ECALL  = 32'h0000_0073;
  localparam logic [31:0] ENC_EBREAK = 32'h0010_0073;
  localparam logic [31:0] ENC_MRET   = 32'h3020_0073;
  localparam logic [31:0] ENC_WFI    = 32'h1050_0073;

  ////////////////////////////////////////////////////////////////////////////
  // Decoded function
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    LUI, AUIPC, JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LB, LH, LW, LD, LBU, LHU, LWU,
    SB, SH, SW, SD,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    ADDIW, SLLIW, SRLIW, SRAIW,
    ADDW, SUBW, SLLW, SRLW, SRAW,
    FENCE, ECALL, EBREAK, MRET, WFI,
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    MULW, DIVW, DIVUW, REMW, REMUW,
    ILLEGAL
  } func_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_SHAMT, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word in its six formats
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_u;

  typedef struct packed {
    func_e                 func;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic                  mem_op;
    logic                  blocking;
    logic [NUM_XREGS-1:0]  reg_req;
  } decoded_instr_t;

endpackage

// ==== src/instr_matcher.sv ====
module instr_matcher
  import rv_decode_pkg::*;
(
  input  instr_u instr_i,
  input  logic   m_ext_en_i,
  output func_e  func_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  func_e      match;
  logic       is_m;  // Hit in the M table

  assign opcode = instr_i.r.opcode;
  assign funct3 = instr_i.r.funct3;
  assign funct7 = instr_i.r.funct7;

  always_comb begin
    match = ILLEGAL;
    is_m  = 1'b0;
    case (opcode)
      OPC_LUI:   match = LUI;
      OPC_AUIPC: match = AUIPC;
      OPC_JAL:   match = JAL;
      OPC_JALR:  if (funct3 == 3'd0) match = JALR;
      OPC_BRANCH: begin
        case (funct3)
          3'd0: match = BEQ;
          3'd1: match = BNE;
          3'd4: match = BLT;
          3'd5: match = BGE;
          3'd6: match = BLTU;
          3'd7: match = BGEU;
          default: match = ILLEGAL;
        endcase
      end
      OPC_LOAD: begin
        case (funct3)
          3'd0: match = LB;
          3'd1: match = LH;
          3'd2: match = LW;
          3'd3: match = LD;
          3'd4: match = LBU;
          3'd5: match = LHU;
          3'd6: match = LWU;
          default: match = ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'd0: match = SB;
          3'd1: match = SH;
          3'd2: match = SW;
          3'd3: match = SD;
          default: match = ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        // RV64 shifts use funct6 and a 6 bit shamt
        case (funct3)
          3'd0: match = ADDI;
          3'd1: if (funct7[6:1] == F7_BASE[6:1]) match = SLLI;
          3'd2: match = SLTI;
          3'd3: match = SLTIU;
          3'd4: match = XORI;
          3'd5: begin
            if (funct7[6:1] == F7_BASE[6:1]) match = SRLI;
            else if (funct7[6:1] == F7_ALT[6:1]) match = SRAI;
          end
          3'd6: match = ORI;
          3'd7: match = ANDI;
        endcase
      end
      OPC_OP_IMM_32: begin
        if (funct3 == 3'd0) match = ADDIW;
        else if (funct3 == 3'd1 && funct7 == F7_BASE) match = SLLIW;
        else if (funct3 == 3'd5 && funct7 == F7_BASE) match = SRLIW;
        else if (funct3 == 3'd5 && funct7 == F7_ALT) match = SRAIW;
      end
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'd0: match = ADD;
            3'd1: match = SLL;
            3'd2: match = SLT;
            3'd3: match = SLTU;
            3'd4: match = XOR;
            3'd5: match = SRL;
            3'd6: match = OR;
            3'd7: match = AND;
          endcase
        end else if (funct7 == F7_ALT) begin
          if (funct3 == 3'd0) match = SUB;
          else if (funct3 == 3'd5) match = SRA;
        end else if (funct7 == F7_MULDIV) begin
          is_m = 1'b1;
          case (funct3)
            3'd0: match = MUL;
            3'd1: match = MULH;
            3'd2: match = MULHSU;
            3'd3: match = MULHU;
            3'd4: match = DIV;
            3'd5: match = DIVU;
            3'd6: match = REM;
            3'd7: match = REMU;
          endcase
        end
      end
      OPC_OP_32: begin
        if (funct7 == F7_BASE) begin
          if (funct3 == 3'd0) match = ADDW;
          else if (funct3 == 3'd1) match = SLLW;
          else if (funct3 == 3'd5) match = SRLW;
        end else if (funct7 == F7_ALT) begin
          if (funct3 == 3'd0) match = SUBW;
          else if (funct3 == 3'd5) match = SRAW;
        end else if (funct7 == F7_MULDIV) begin
          is_m = 1'b1;
          case (funct3)
            3'd0: match = MULW;
            3'd4: match = DIVW;
            3'd5: match = DIVUW;
            3'd6: match = REMW;
            3'd7: match = REMUW;
            default: match = ILLEGAL;
          endcase
        end
      end
      OPC_MISC_MEM: if (funct3 == 3'd0) match = FENCE;
      OPC_SYSTEM: begin
        case (instr_i)
          ENC_ECALL:  match = ECALL;
          ENC_EBREAK: match = EBREAK;
          ENC_MRET:   match = MRET;
          ENC_WFI:    match = WFI;
          default:    match = ILLEGAL;
        endcase
      end
      default: match = ILLEGAL;
    endcase
  end

  assign func_o = (is_m && !m_ext_en_i) ? ILLEGAL : match;

endmodule

// ==== src/operand_decode.sv ====
module operand_decode
  import rv_decode_pkg::*;
(
  input  instr_u          instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  func_e           func_i,
  output decoded_instr_t  dec_o
);

  logic     use_rd;
  logic     use_rs1;
  logic     use_rs2;
  imm_sel_e imm_sel;
  logic     mem_op;
  logic     blocking;

  logic [XLEN-1:0] imm_shamt;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  ////////////////////////////////////////////////////////////////////////////
  // Operand usage per function
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    use_rd   = 1'b0;
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    imm_sel  = IMM_NONE;
    mem_op   = 1'b0;
    blocking = 1'b0;
    case (func_i)
      LUI, AUIPC: begin
        use_rd  = 1'b1;
        imm_sel = IMM_U;
      end
      JAL: begin
        use_rd   = 1'b1;
        imm_sel  = IMM_J;
        blocking = 1'b1;
      end
      JALR: begin
        use_rd   = 1'b1;
        use_rs1  = 1'b1;
        imm_sel  = IMM_I;
        blocking = 1'b1;
      end
      BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        imm_sel  = IMM_B;
        blocking = 1'b1;
      end
      LB, LH, LW, LD, LBU, LHU, LWU: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        imm_sel = IMM_I;
        mem_op  = 1'b1;
      end
      SB, SH, SW, SD: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm_sel = IMM_S;
        mem_op  = 1'b1;
      end
      ADDI, SLTI, SLTIU, XORI, ORI, ANDI, ADDIW: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        imm_sel = IMM_I;
      end
      SLLI, SRLI, SRAI, SLLIW, SRLIW, SRAIW: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        imm_sel = IMM_SHAMT;
      end
      FENCE: begin
        imm_sel  = IMM_I;  // pred/succ bits
        blocking = 1'b1;
      end
      MRET, WFI, ILLEGAL: blocking = 1'b1;
      ECALL, EBREAK: blocking = 1'b0;
      default: begin
        // Register-register ops including the M extension
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////////////////////

  assign imm_shamt = {{(XLEN-6){1'b0}}, instr_i.i.imm_11_0[5:0]};
  assign imm_i = {{(XLEN-12){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
  assign imm_s = {{(XLEN-12){instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
  assign imm_b = {{(XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11, instr_i.b.imm_10_5,
                  instr_i.b.imm_4_1, 1'b0};
  assign imm_u = {{(XLEN-32){instr_i.u.imm_31_12[19]}}, instr_i.u.imm_31_12, 12'b0};
  assign imm_j = {{(XLEN-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12, instr_i.j.imm_11,
                  instr_i.j.imm_10_1, 1'b0};

  always_comb begin
    dec_o.func     = func_i;
    dec_o.rd       = use_rd  ? instr_i.r.rd  : '0;
    dec_o.rs1      = use_rs1 ? instr_i.r.rs1 : '0;
    dec_o.rs2      = use_rs2 ? instr_i.r.rs2 : '0;
    dec_o.pc       = pc_i;
    dec_o.mem_op   = mem_op;
    dec_o.blocking = blocking;
    case (imm_sel)
      IMM_SHAMT: dec_o.imm = imm_shamt;
      IMM_I:     dec_o.imm = imm_i;
      IMM_S:     dec_o.imm = imm_s;
      IMM_B:     dec_o.imm = imm_b;
      IMM_U:     dec_o.imm = imm_u;
      IMM_J:     dec_o.imm = imm_j;
      default:   dec_o.imm = '0;
    endcase
    // Unused fields sit at x0, so bit 0 is set as well
    dec_o.reg_req             = '0;
    dec_o.reg_req[dec_o.rd]   = 1'b1;
    dec_o.reg_req[dec_o.rs1]  = 1'b1;
    dec_o.reg_req[dec_o.rs2]  = 1'b1;
    if (blocking) dec_o.reg_req = '1;  // Stall on every register
  end

endmodule

// ==== src/decode_cfg_regs.sv ====
module decode_cfg_regs
  import rv_decode_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cfg_wr_i,
  input  logic [31:0] cfg_wdata_i,
  input  logic        illegal_seen_i,
  output logic        m_ext_en_o,
  output logic [31:0] cfg_rdata_o
);

  logic             m_ext_en_q;
  logic [CNT_W-1:0] illegal_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Enable and illegal counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      m_ext_en_q    <= 1'b1;
      illegal_cnt_q <= '0;
    end else if (cfg_wr_i) begin
      // A write also restarts the count
      m_ext_en_q    <= cfg_wdata_i[0];
      illegal_cnt_q <= '0;
    end else if (illegal_seen_i && (illegal_cnt_q != '1)) begin
      illegal_cnt_q <= illegal_cnt_q + 1'b1;  // Saturates at all ones
    end
  end

  assign m_ext_en_o  = m_ext_en_q;
  assign cfg_rdata_o = {{(32-CNT_W-1){1'b0}}, illegal_cnt_q, m_ext_en_q};

endmodule

// ==== src/decode_credit_stage.sv ====
module decode_credit_stage
  import rv_decode_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           in_valid_i,
  input  decoded_instr_t dec_i,
  input  logic           credit_return_i,
  output logic           in_ready_o,
  output logic           out_valid_o,
  output decoded_instr_t out_instr_o
);

  logic [CREDIT_W-1:0] credit_cnt_q;
  logic                take;
  logic                out_valid_q;
  decoded_instr_t      out_instr_q;

  assign in_ready_o = (credit_cnt_q != '0);
  assign take       = in_valid_i & in_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Credits and output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt_q <= CREDIT_W'(CREDITS);
      out_valid_q  <= 1'b0;
    end else begin
      out_valid_q <= take;
      if (take && !credit_return_i) begin
        credit_cnt_q <= credit_cnt_q - 1'b1;
      end else if (!take && credit_return_i) begin
        credit_cnt_q <= credit_cnt_q + 1'b1;
      end
    end
  end

  // Payload only moves on a take
  always_ff @(posedge clk_i) begin
    if (take) begin
      out_instr_q <= dec_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_instr_o = out_instr_q;

endmodule

// ==== src/rv_instr_decoder.sv ====
module rv_instr_decoder
  import rv_decode_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            in_valid_i,
  input  instr_u          instr_i,
  input  logic [XLEN-1:0] pc_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  output decoded_instr_t  out_instr_o,
  input  logic            credit_return_i,
  input  logic            cfg_wr_i,
  input  logic [31:0]     cfg_wdata_i,
  output logic [31:0]     cfg_rdata_o
);

  func_e          func;
  decoded_instr_t dec;
  logic           m_ext_en;
  logic           illegal_seen;

  // Count only words actually taken
  assign illegal_seen = in_valid_i & in_ready_o & (func == ILLEGAL);

  instr_matcher u_instr_matcher (
    .instr_i    (instr_i),
    .m_ext_en_i (m_ext_en),
    .func_o     (func)
  );

  operand_decode u_operand_decode (
    .instr_i (instr_i),
    .pc_i    (pc_i),
    .func_i  (func),
    .dec_o   (dec)
  );

  decode_cfg_regs u_decode_cfg_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cfg_wr_i       (cfg_wr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .illegal_seen_i (illegal_seen),
    .m_ext_en_o     (m_ext_en),
    .cfg_rdata_o    (cfg_rdata_o)
  );

  decode_credit_stage u_decode_credit_stage (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (in_valid_i),
    .dec_i           (dec),
    .credit_return_i (credit_return_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_instr_o     (out_instr_o)
  );

endmodule

// ==== dv/decode_ref.svh ====
// RV64 encoders with the fields laid out as in the base ISA

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] opc);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

// Branch offset is 13 bits with bit 0 dropped
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] opc);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
endfunction

// Sign extend the low width bits to 64
function automatic logic [63:0] sext(input logic [63:0] val, input int width);
  logic [63:0] up;
  up = val << (64 - width);
  return $signed(up) >>> (64 - width);
endfunction

// One bit per register read or written
function automatic logic [31:0] exp_reg_req(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
  return (32'd1 << rd) | (32'd1 << rs1) | (32'd1 << rs2);
endfunction

// ==== dv/tb_rv_instr_decoder.sv ====
module tb_rv_instr_decoder
  import rv_decode_pkg::*;
();

  localparam int WAIT_MAX = 20;

  logic            clk_i;
  logic            rst_n_i;
  logic            in_valid_i;
  instr_u          instr_i;
  logic [XLEN-1:0] pc_i;
  logic            in_ready_o;
  logic            out_valid_o;
  decoded_instr_t  out_instr_o;
  logic            credit_return_i;
  logic            cfg_wr_i;
  logic [31:0]     cfg_wdata_i;
  logic [31:0]     cfg_rdata_o;

  int seed;
  int errors;
  int test_errs;
  int tests_run;

  `include "decode_ref.svh"

  rv_instr_decoder u_rv_instr_decoder (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (in_valid_i),
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_instr_o     (out_instr_o),
    .credit_return_i (credit_return_i),
    .cfg_wr_i        (cfg_wr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .cfg_rdata_o     (cfg_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    test_errs++;
  endtask

  task automatic report_problem(input string what);
    $display("[ERROR] %s", what);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    errors += test_errs;
    $display("%s: %s, %0d errors", name, (test_errs == 0) ? "passed" : "failed", test_errs);
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus helpers entered and left at a falling edge
  ////////////////////////////////////////////////////////////////////////////

  // Offer one word, collect its decoded form, then hand the credit back
  task automatic issue(input logic [31:0] word, input logic [XLEN-1:0] pc,
                       output decoded_instr_t got, output logic taken);
    int waited;
    got        = '0;
    taken      = 1'b0;
    in_valid_i = 1'b1;
    instr_i    = word;
    pc_i       = pc;
    waited     = 0;
    while (!in_ready_o && waited < WAIT_MAX) begin
      @(negedge clk_i);
      waited++;
    end
    if (!in_ready_o) begin
      in_valid_i = 1'b0;
      report_problem("in_ready_o stayed low, instruction was never accepted");
    end else begin
      @(negedge clk_i);  // Taken on the rising edge in between
      in_valid_i = 1'b0;
      waited     = 0;
      while (!out_valid_o && waited < WAIT_MAX) begin
        @(negedge clk_i);
        waited++;
      end
      if (!out_valid_o) begin
        report_problem("out_valid_o never rose after an accepted instruction");
      end else begin
        if (waited != 0) report_problem("decoded word arrived later than one cycle");
        got             = out_instr_o;
        taken           = 1'b1;
        credit_return_i = 1'b1;
        @(negedge clk_i);
        credit_return_i = 1'b0;
      end
    end
  endtask

  task automatic cfg_write(input logic [31:0] data);
    cfg_wr_i    = 1'b1;
    cfg_wdata_i = data;
    @(negedge clk_i);
    cfg_wr_i    = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_imm_case(input string tag, input logic [31:0] word, input func_e func,
                                input logic [XLEN-1:0] imm, input logic mem_op);
    decoded_instr_t  got;
    logic            taken;
    logic [XLEN-1:0] pc;
    pc = {$random(seed), $random(seed)};
    issue(word, pc, got, taken);
    if (taken) begin
      if (got.func !== func) begin
        report_mismatch({"out_instr_o.func of ", tag}, 64'(got.func), 64'(func));
      end
      if (got.imm !== imm) report_mismatch({"out_instr_o.imm of ", tag}, got.imm, imm);
      if (got.pc !== pc) report_mismatch({"out_instr_o.pc of ", tag}, got.pc, pc);
      if (got.mem_op !== mem_op) begin
        report_mismatch({"out_instr_o.mem_op of ", tag}, 64'(got.mem_op), 64'(mem_op));
      end
    end
  endtask

  task automatic test_imm_formats();
    check_imm_case("ADDI", enc_i(12'hffd, 5'd6, 3'd0, 5'd5, 7'h13), ADDI,
                   sext(64'hffd, 12), 1'b0);
    check_imm_case("SW", enc_s(12'hfec, 5'd7, 5'd8, 3'd2, 7'h23), SW,
                   sext(64'hfec, 12), 1'b1);
    check_imm_case("BNE", enc_b(13'h1ff8, 5'd2, 5'd1, 3'd1, 7'h63), BNE,
                   sext(64'h1ff8, 13), 1'b0);
    check_imm_case("LUI", enc_u(20'h80001, 5'd9, 7'h37), LUI,
                   sext(64'h8000_1000, 32), 1'b0);
    check_imm_case("JAL", enc_j(21'h10_0a44, 5'd1, 7'h6f), JAL,
                   sext(64'h10_0a44, 21), 1'b0);
    // funct6 of SRAI with a 6 bit shamt
    check_imm_case("SRAI", enc_i({6'b010000, 6'd45}, 5'd4, 3'd5, 5'd3, 7'h13), SRAI,
                   64'd45, 1'b0);
    finish_test("imm_formats");
  endtask

  task automatic test_reg_fields();
    decoded_instr_t got;
    logic           taken;
    logic [4:0]     rd;
    logic [4:0]     rs1;
    logic [4:0]     rs2;
    logic [31:0]    word;
    func_e          func;
    int             n;
    for (n = 0; n < 9; n++) begin
      rd  = 5'($random(seed));
      rs1 = 5'($random(seed));
      rs2 = 5'($random(seed));
      case (n % 3)
        0: begin
          word = enc_r(7'h00, rs2, rs1, 3'd0, rd, 7'h33);
          func = ADD;
        end
        1: begin
          word = enc_r(7'h20, rs2, rs1, 3'd0, rd, 7'h3b);
          func = SUBW;
        end
        default: begin
          word = enc_r(7'h00, rs2, rs1, 3'd2, rd, 7'h33);
          func = SLT;
        end
      endcase
      issue(word, 64'h100 + 64'(n * 4), got, taken);
      if (taken) begin
        if (got.func !== func) report_mismatch("out_instr_o.func", 64'(got.func), 64'(func));
        if (got.rd !== rd) report_mismatch("out_instr_o.rd", 64'(got.rd), 64'(rd));
        if (got.rs1 !== rs1) report_mismatch("out_instr_o.rs1", 64'(got.rs1), 64'(rs1));
        if (got.rs2 !== rs2) report_mismatch("out_instr_o.rs2", 64'(got.rs2), 64'(rs2));
        if (got.reg_req !== exp_reg_req(rd, rs1, rs2)) begin
          report_mismatch("out_instr_o.reg_req", 64'(got.reg_req),
                          64'(exp_reg_req(rd, rs1, rs2)));
        end
      end
    end
    // LUI reads no register, whatever sits in its upper bits
    rd   = 5'($random(seed));
    word = enc_u(20'($random(seed)), rd, 7'h37);
    issue(word, 64'h200, got, taken);
    if (taken) begin
      if (got.rd !== rd) report_mismatch("out_instr_o.rd", 64'(got.rd), 64'(rd));
      if (got.rs1 !== 5'd0) report_mismatch("out_instr_o.rs1", 64'(got.rs1), 64'd0);
      if (got.rs2 !== 5'd0) report_mismatch("out_instr_o.rs2", 64'(got.rs2), 64'd0);
      if (got.reg_req !== exp_reg_req(rd, 5'd0, 5'd0)) begin
        report_mismatch("out_instr_o.reg_req", 64'(got.reg_req),
                        64'(exp_reg_req(rd, 5'd0, 5'd0)));
      end
    end
    finish_test("reg_fields");
  endtask

  task automatic test_m_ext_enable();
    decoded_instr_t got;
    logic           taken;
    logic [31:0]    mul_word;
    mul_word = enc_r(7'h01, 5'd12, 5'd11, 3'd0, 5'd10, 7'h33);
    issue(mul_word, 64'h1000, got, taken);
    if (taken && got.func !== MUL) report_mismatch("out_instr_o.func", 64'(got.func), 64'(MUL));
    cfg_write(32'h0);
    if (cfg_rdata_o[0] !== 1'b0) report_mismatch("cfg_rdata_o[0]", 64'(cfg_rdata_o[0]), 64'd0);
    issue(mul_word, 64'h1004, got, taken);
    if (taken) begin
      if (got.func !== ILLEGAL) begin
        report_mismatch("out_instr_o.func", 64'(got.func), 64'(ILLEGAL));
      end
      if (got.blocking !== 1'b1) begin
        report_mismatch("out_instr_o.blocking", 64'(got.blocking), 64'd1);
      end
      if (got.reg_req !== 32'hffff_ffff) begin
        report_mismatch("out_instr_o.reg_req", 64'(got.reg_req), 64'hffff_ffff);
      end
    end
    cfg_write(32'h1);
    issue(mul_word, 64'h1008, got, taken);
    if (taken && got.func !== MUL) report_mismatch("out_instr_o.func", 64'(got.func), 64'(MUL));
    finish_test("m_ext_enable");
  endtask

  task automatic test_illegal_count();
    decoded_instr_t got;
    logic           taken;
    logic [31:0]    words [5];
    logic           bad [5];
    int             n;
    words[0] = 32'h0000_0000;
    words[1] = enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33);
    words[2] = 32'hffff_ffff;
    words[3] = enc_i(12'h010, 5'd2, 3'd0, 5'd2, 7'h13);
    words[4] = 32'h0000_2007;  // FLW is illegal without the F extension
    bad      = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    cfg_write(32'h1);
    for (n = 0; n < 5; n++) begin
      issue(words[n], 64'h3000 + 64'(n * 4), got, taken);
      if (taken && bad[n] && got.func !== ILLEGAL) begin
        report_mismatch("out_instr_o.func", 64'(got.func), 64'(ILLEGAL));
      end
    end
    if (cfg_rdata_o[16:1] !== 16'd3) begin
      report_mismatch("cfg_rdata_o[16:1]", 64'(cfg_rdata_o[16:1]), 64'd3);
    end
    finish_test("illegal_count");
  endtask

  task automatic test_credit_flow();
    int   accepted;
    int   cycles;
    logic ready_now;
    accepted   = 0;
    cycles     = 0;
    in_valid_i = 1'b1;
    pc_i       = 64'h4000;
    // No credits come back here, so the stage has to stall
    while (cycles < CREDITS + 3) begin
      instr_i   = enc_i(12'h001, 5'd0, 3'd0, 5'(accepted + 1), 7'h13);
      ready_now = in_ready_o;
      @(negedge clk_i);
      if (out_valid_o !== ready_now) begin
        report_mismatch("out_valid_o", 64'(out_valid_o), 64'(ready_now));
      end
      if (ready_now && out_instr_o.rd !== 5'(accepted + 1)) begin
        report_mismatch("out_instr_o.rd", 64'(out_instr_o.rd), 64'(accepted + 1));
      end
      if (ready_now) accepted++;
      cycles++;
    end
    if (accepted != CREDITS) begin
      report_problem($sformatf("%0d instructions accepted without credits instead of %0d",
                               accepted, CREDITS));
    end
    if (in_ready_o !== 1'b0) report_mismatch("in_ready_o", 64'(in_ready_o), 64'd0);
    credit_return_i = 1'b1;
    @(negedge clk_i);
    credit_return_i = 1'b0;
    if (in_ready_o !== 1'b1) report_mismatch("in_ready_o", 64'(in_ready_o), 64'd1);
    instr_i = enc_i(12'h001, 5'd0, 3'd0, 5'd31, 7'h13);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    if (out_valid_o !== 1'b1) report_mismatch("out_valid_o", 64'(out_valid_o), 64'd1);
    if (out_instr_o.rd !== 5'd31) report_mismatch("out_instr_o.rd", 64'(out_instr_o.rd), 64'd31);
    // Consumer drains its queue
    credit_return_i = 1'b1;
    repeat (CREDITS) @(negedge clk_i);
    credit_return_i = 1'b0;
    if (in_ready_o !== 1'b1) report_mismatch("in_ready_o", 64'(in_ready_o), 64'd1);
    finish_test("credit_flow");
  endtask

  task automatic check_block_case(input logic [31:0] word, input func_e func,
                                  input logic blocking, input logic [31:0] reg_req);
    decoded_instr_t got;
    logic           taken;
    issue(word, 64'h5000, got, taken);
    if (taken) begin
      if (got.func !== func) report_mismatch("out_instr_o.func", 64'(got.func), 64'(func));
      if (got.blocking !== blocking) begin
        report_mismatch("out_instr_o.blocking", 64'(got.blocking), 64'(blocking));
      end
      if (got.reg_req !== reg_req) begin
        report_mismatch("out_instr_o.reg_req", 64'(got.reg_req), 64'(reg_req));
      end
    end
  endtask

  task automatic test_blocking();
    check_block_case(enc_b(13'h0010, 5'd2, 5'd1, 3'd0, 7'h63), BEQ, 1'b1, 32'hffff_ffff);
    check_block_case(enc_i(12'h004, 5'd1, 3'd0, 5'd1, 7'h67), JALR, 1'b1, 32'hffff_ffff);
    check_block_case(32'h0ff0_000f, FENCE, 1'b1, 32'hffff_ffff);
    check_block_case(32'h3020_0073, MRET, 1'b1, 32'hffff_ffff);
    check_block_case(32'h1050_0073, WFI, 1'b1, 32'hffff_ffff);
    check_block_case(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33), ADD, 1'b0,
                     exp_reg_req(5'd1, 5'd2, 5'd3));
    finish_test("blocking");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed            = 54;
    errors          = 0;
    test_errs       = 0;
    tests_run       = 0;
    rst_n_i         = 1'b0;
    in_valid_i      = 1'b0;
    instr_i         = '0;
    pc_i            = '0;
    credit_return_i = 1'b0;
    cfg_wr_i        = 1'b0;
    cfg_wdata_i     = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if (in_ready_o !== 1'b1) report_mismatch("in_ready_o", 64'(in_ready_o), 64'd1);
    if (out_valid_o !== 1'b0) report_mismatch("out_valid_o", 64'(out_valid_o), 64'd0);
    if (cfg_rdata_o !== 32'h1) report_mismatch("cfg_rdata_o", 64'(cfg_rdata_o), 64'h1);
    finish_test("reset_state");
    test_imm_formats();
    test_reg_fields();
    test_m_ext_enable();
    test_illegal_count();
    test_credit_flow();
    test_blocking();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+dv
src/rv_decode_pkg.sv
src/instr_matcher.sv
src/operand_decode.sv
src/decode_cfg_regs.sv
src/decode_credit_stage.sv
src/rv_instr_decoder.sv
dv/tb_rv_instr_decoder.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := tb_rv_instr_decoder
FILELIST  := project.f
BUILD_DIR := obj_dir
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
